// File: common/wb_pkg.sv
`default_nettype none

package wb_pkg;

    // Data path widths
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;   // One data word
    typedef logic [4:0]      reg_addr_t; // GPR address
    typedef logic [5:0]      fu_t;     // One-hot functional unit
    typedef logic [4:0]      uop_t;    // Micro-op
    typedef logic [5:0]      cause_t;  // Trap cause

    // Functional unit bit positions
    localparam int P_FU_ALU = 0;
    localparam int P_FU_MUL = 1;
    localparam int P_FU_LSU = 2;
    localparam int P_FU_CFU = 3;
    localparam int P_FU_CSR = 4;
    localparam int P_FU_CRY = 5;

    // CSR micro-op bits
    localparam int CSR_READ  = 4;
    localparam int CSR_WRITE = 3;
    localparam int CSR_SET   = 2;
    localparam int CSR_CLEAR = 1;

    // LSU micro-op fields, size code in bits 2..1
    localparam int LSU_LOAD   = 3;
    localparam int LSU_STORE  = 4;
    localparam int LSU_SIGNED = 0;
    localparam logic [1:0] LSU_BYTE = 2'b01;
    localparam logic [1:0] LSU_HALF = 2'b10;
    localparam logic [1:0] LSU_WORD = 2'b11;

    // Control flow micro-ops
    localparam uop_t CFU_TAKEN  = 5'b01001;
    localparam uop_t CFU_JALI   = 5'b10010;
    localparam uop_t CFU_JALR   = 5'b10100;
    localparam uop_t CFU_EBREAK = 5'b00001;
    localparam uop_t CFU_ECALL  = 5'b00010;
    localparam uop_t CFU_MRET   = 5'b00100;

    // Exception codes as in mcause
    localparam cause_t TRAP_IOPCODE  = 6'd2;
    localparam cause_t TRAP_BREAKPT  = 6'd3;
    localparam cause_t TRAP_LDALIGN  = 6'd4;
    localparam cause_t TRAP_LDACCESS = 6'd5;
    localparam cause_t TRAP_STALIGN  = 6'd6;
    localparam cause_t TRAP_STACCESS = 6'd7;
    localparam cause_t TRAP_ECALLM   = 6'd11;

endpackage

`default_nettype wire

// File: common/wb_instr_if.sv
`timescale 1ns/1ps
`default_nettype none

// Instruction held in the writeback stage
interface wb_instr_if import wb_pkg::*; ();

    reg_addr_t rd;     // Dest reg, or trap cause when trap set
    word_t     opr_a;  // Result or jump target
    word_t     opr_b;  // Mem address or CSR address
    uop_t      uop;
    fu_t       fu;
    logic      trap;   // Trap raised upstream
    logic [1:0] size;  // Length in half words
    logic      valid;

    // Data side of the stage
    modport sink (input rd, opr_a, opr_b, uop, fu, trap, size, valid);

    // Sequencing only needs the unit, op and length
    modport ctrl (input fu, uop, size, valid);

endinterface

`default_nettype wire

// File: writeback_ctrl/wb_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module wb_sequencer import wb_pkg::*; (
    input  logic       g_clk,
    input  logic       g_resetn,
    wb_instr_if.ctrl   instr,
    input  logic       cf_req,       // Change wanted this cycle
    input  logic       cf_ack,
    input  logic       int_trap_req,
    input  logic       gpr_any,      // Instruction would write a GPR
    output logic       s4_busy,
    output logic       progress,
    output logic       cf_done,
    output logic       csr_en,
    output logic       gpr_wen,
    output logic       trap_int,
    output logic       exec_mret,
    output logic       trs_valid,
    output logic       hold_lsu_req
);

    logic csr_done;    // CSR access already issued
    logic gpr_done;    // GPR already written
    logic int_pending; // Interrupt seen while stalled
    logic cf_finish;   // Change acknowledged this cycle

    assign cf_finish = cf_req && cf_ack;

    // Stall only while an unfinished change waits for ack
    assign s4_busy   = cf_req && !cf_ack && !cf_done;
    assign progress  = instr.valid && !s4_busy;

    // One-shot enables ----------------------------------------
    assign csr_en    = instr.valid && instr.fu[P_FU_CSR] && !csr_done;
    assign gpr_wen   = instr.valid && gpr_any && !gpr_done;

    assign trap_int  = int_trap_req || int_pending;
    assign exec_mret = instr.fu[P_FU_CFU] && (instr.uop == CFU_MRET) && progress;

    // Retire on progress, or on a change with no instruction behind it
    assign trs_valid = |instr.size && (progress || (cf_finish && !cf_done));

    // No new memory requests until the trap decision settles
    assign hold_lsu_req = cf_req || trap_int;

    // Done flags ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            csr_done <= 1'b0;
            cf_done  <= 1'b0;
            gpr_done <= 1'b0;
        end else begin
            csr_done <= !progress && (csr_done || csr_en);
            cf_done  <= !progress && (cf_done || cf_finish); // Acked but still stalled
            if (progress)
                gpr_done <= 1'b0;
            else if (gpr_wen)
                gpr_done <= 1'b1;
        end
    end

    // Interrupt held until its change completes
    always_ff @(posedge g_clk) begin
        if (!g_resetn)
            int_pending <= 1'b0;
        else if (int_pending)
            int_pending <= !cf_finish;
        else
            int_pending <= int_trap_req && !progress;
    end

endmodule

`default_nettype wire

// File: writeback_ctrl/wb_pc_counter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_pc_counter import wb_pkg::*; #(
    parameter word_t PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic       g_clk,
    input  logic       g_resetn,
    input  logic       progress,  // Instruction leaves the stage
    input  logic       cf_fire,   // Completed control flow change
    input  word_t      cf_target,
    input  logic [1:0] size,      // Half words
    output word_t      pc,
    output word_t      pc_next    // Sequential successor, also link value
);

    assign pc_next = pc + {{(XLEN-3){1'b0}}, size, 1'b0};

    // Redirect wins over sequential step
    always_ff @(posedge g_clk) begin
        if (!g_resetn)
            pc <= PC_RESET_VALUE;
        else if (cf_fire)
            pc <= cf_target;
        else if (progress)
            pc <= pc_next;
    end

endmodule

`default_nettype wire

// File: writeback_ctrl/wb_trap_unit.sv
`timescale 1ns/1ps
`default_nettype none

module wb_trap_unit import wb_pkg::*; (
    wb_instr_if.sink  instr,
    input  word_t     pc,
    input  logic      trap_int,        // Interrupt being taken
    input  cause_t    int_trap_cause,
    input  logic      lsu_error,       // Data bus error on this load/store
    input  logic      csr_error,
    input  word_t     csr_mepc,
    input  word_t     csr_mtvec,
    input  logic      vector_intrs,
    output logic      cf_req,
    output word_t     cf_target,
    output logic      trap_cpu,
    output cause_t    trap_cause,
    output word_t     trap_mtval
);

    logic fu_cfu, fu_csr, fu_lsu;
    logic cfu_taken, cfu_ebreak, cfu_ecall, cfu_mret;
    logic csr_trap, cpu_trap, addr_align;
    word_t trap_target;

    assign fu_cfu = instr.valid && instr.fu[P_FU_CFU];
    assign fu_csr = instr.valid && instr.fu[P_FU_CSR];
    assign fu_lsu = instr.valid && instr.fu[P_FU_LSU];

    // Control flow decode ----------------------------------------
    assign cfu_taken  = fu_cfu && (instr.uop == CFU_TAKEN || instr.uop == CFU_JALI ||
                                   instr.uop == CFU_JALR);
    assign cfu_ebreak = fu_cfu && (instr.uop == CFU_EBREAK);
    assign cfu_ecall  = fu_cfu && (instr.uop == CFU_ECALL);
    assign cfu_mret   = fu_cfu && (instr.uop == CFU_MRET);
    assign csr_trap   = fu_csr && csr_error;  // Illegal CSR access

    // Any exception from the instruction itself
    assign cpu_trap = cfu_ebreak || cfu_ecall || csr_trap || lsu_error ||
                      (instr.valid && instr.trap);

    assign cf_req   = cfu_taken || cfu_mret || cpu_trap || trap_int;
    assign trap_cpu = !trap_int && cpu_trap;

    // Vectored mode adds 4 x cause for interrupts only
    assign trap_target = csr_mtvec + ((vector_intrs && trap_int) ?
                         {{(XLEN-8){1'b0}}, int_trap_cause, 2'b00} : '0);

    assign cf_target = (cpu_trap || trap_int) ? trap_target :
                       cfu_mret               ? csr_mepc    :
                       cfu_taken              ? instr.opr_a : '0;

    // Misaligned access reported upstream in rd
    assign addr_align = instr.trap && ({1'b0, instr.rd} == TRAP_LDALIGN ||
                                       {1'b0, instr.rd} == TRAP_STALIGN);

    assign trap_cause = lsu_error && fu_lsu && instr.uop[LSU_LOAD]  ? TRAP_LDACCESS :
                        lsu_error && fu_lsu && instr.uop[LSU_STORE] ? TRAP_STACCESS :
                        cfu_ebreak ? TRAP_BREAKPT   :
                        cfu_ecall  ? TRAP_ECALLM    :
                        csr_trap   ? TRAP_IOPCODE   :
                        trap_int   ? int_trap_cause :
                                     {1'b0, instr.rd};

    assign trap_mtval = cfu_ebreak               ? pc          :
                        (lsu_error || addr_align) ? instr.opr_b : '0;

endmodule

`default_nettype wire

// File: design/wb_load_unit.sv
`timescale 1ns/1ps
`default_nettype none

module wb_load_unit import wb_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    wb_instr_if.sink  instr,
    input  logic      progress,
    input  logic      dmem_req,
    input  logic      dmem_gnt,
    input  logic      dmem_error,
    input  word_t     dmem_rdata,
    output word_t     load_data,
    output logic      lsu_error   // Bus error for the held load/store
);

    logic       dmem_rsp;  // Response cycle
    logic       err_q;
    logic       lsu_byte, lsu_half, lsu_word, lsu_signed;
    logic [1:0] addr_lo;
    logic [3:0] strb;      // Byte lanes from memory stage
    logic [7:0] b0, b1;
    logic [15:0] h1;

    always_ff @(posedge g_clk) begin
        if (!g_resetn)
            dmem_rsp <= 1'b0;
        else
            dmem_rsp <= dmem_req && dmem_gnt;
    end

    // Error held until the instruction leaves
    always_ff @(posedge g_clk) begin
        if (!g_resetn || progress)
            err_q <= 1'b0;
        else if (dmem_rsp && dmem_error)
            err_q <= 1'b1;
    end

    assign lsu_error = instr.valid && instr.fu[P_FU_LSU] && ((dmem_rsp && dmem_error) || err_q);

    // Alignment ----------------------------------------
    assign lsu_byte   = instr.uop[2:1] == LSU_BYTE;
    assign lsu_half   = instr.uop[2:1] == LSU_HALF;
    assign lsu_word   = instr.uop[2:1] == LSU_WORD;
    assign lsu_signed = instr.uop[LSU_SIGNED];
    assign addr_lo    = instr.opr_b[1:0];
    assign strb       = instr.opr_a[3:0];

    assign b0 = {8{strb[0]}}                      & dmem_rdata[7:0]   |
                {8{lsu_byte && addr_lo == 2'b01}} & dmem_rdata[15:8]  |
                {8{lsu_byte && addr_lo == 2'b10}} & dmem_rdata[23:16] |
                {8{lsu_half && addr_lo[1]}}       & dmem_rdata[23:16] |
                {8{lsu_byte && addr_lo == 2'b11}} & dmem_rdata[31:24];

    assign b1 = {8{lsu_byte && lsu_signed}}       & {8{b0[7]}}        |
                {8{lsu_half && !addr_lo[1]}}      & dmem_rdata[15:8]  |
                {8{lsu_half && addr_lo[1]}}       & dmem_rdata[31:24] |
                {8{lsu_word}}                     & dmem_rdata[15:8];

    assign h1 = {16{(lsu_byte || lsu_half) && lsu_signed}} & {16{b1[7]}} |
                {16{lsu_word}}                            & dmem_rdata[31:16];

    assign load_data = {h1, b1, b0};

endmodule

`default_nettype wire

// File: design/wb_result_mux.sv
`timescale 1ns/1ps
`default_nettype none

module wb_result_mux import wb_pkg::*; (
    wb_instr_if.sink  instr,
    input  logic      trap_int,
    input  word_t     pc_next,    // Link value
    input  word_t     load_data,
    input  word_t     csr_rdata,
    input  logic      csr_error,
    input  logic      csr_en,     // First cycle of CSR access
    output logic      gpr_any,
    output reg_addr_t gpr_rd,
    output word_t     gpr_wdata,
    output logic      csr_wr,
    output logic      csr_wr_set,
    output logic      csr_wr_clr,
    output logic [11:0] csr_addr,
    output word_t     csr_wdata
);

    logic fu_csr, opa_wen, lsu_wen, csr_wen, link_wen;

    // CSR access ----------------------------------------
    assign fu_csr     = instr.fu[P_FU_CSR];
    assign csr_wr     = fu_csr && instr.uop[CSR_WRITE];
    assign csr_wr_set = fu_csr && instr.uop[CSR_SET];
    assign csr_wr_clr = fu_csr && instr.uop[CSR_CLEAR];
    assign csr_addr   = instr.opr_b[11:0];
    assign csr_wdata  = instr.opr_a;

    // Write sources ----------------------------------------
    assign opa_wen  = instr.fu[P_FU_ALU] || instr.fu[P_FU_MUL] || instr.fu[P_FU_CRY];
    assign lsu_wen  = instr.fu[P_FU_LSU] && instr.uop[LSU_LOAD];
    assign csr_wen  = fu_csr && instr.uop[CSR_READ] && csr_en && !csr_error;
    assign link_wen = instr.fu[P_FU_CFU] && (instr.uop == CFU_JALI || instr.uop == CFU_JALR);

    // Trapped instructions never write
    assign gpr_any = !instr.trap && !trap_int && (opa_wen || lsu_wen || csr_wen || link_wen);
    assign gpr_rd  = instr.rd;

    assign gpr_wdata = {XLEN{opa_wen}}  & instr.opr_a |
                       {XLEN{lsu_wen}}  & load_data   |
                       {XLEN{csr_wen}}  & csr_rdata   |
                       {XLEN{link_wen}} & pc_next;

endmodule

`default_nettype wire

// File: design/frv_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module frv_writeback import wb_pkg::*; #(
    parameter word_t PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  reg_addr_t   s4_rd,
    input  word_t       s4_opr_a,
    input  word_t       s4_opr_b,
    input  uop_t        s4_uop,
    input  fu_t         s4_fu,
    input  logic        s4_trap,
    input  logic [1:0]  s4_size,
    input  logic [31:0] s4_instr,
    input  logic        s4_valid,
    output logic        s4_busy,
    output logic        gpr_wen,
    output reg_addr_t   gpr_rd,
    output word_t       gpr_wdata,
    input  logic        int_trap_req,
    input  cause_t      int_trap_cause,
    output logic        trap_cpu,
    output logic        trap_int,
    output cause_t      trap_cause,
    output word_t       trap_mtval,
    output word_t       trap_pc,
    output logic        exec_mret,
    input  word_t       csr_mepc,
    input  word_t       csr_mtvec,
    input  logic        vector_intrs,
    output word_t       trs_pc,
    output logic [31:0] trs_instr,
    output logic        trs_valid,
    output logic        csr_en,
    output logic        csr_wr,
    output logic        csr_wr_set,
    output logic        csr_wr_clr,
    output logic [11:0] csr_addr,
    output word_t       csr_wdata,
    input  word_t       csr_rdata,
    input  logic        csr_error,
    output logic        cf_req,
    output word_t       cf_target,
    input  logic        cf_ack,
    output logic        hold_lsu_req,
    input  logic        dmem_req,
    input  logic        dmem_gnt,
    input  logic        dmem_error,
    input  word_t       dmem_rdata
);

    logic  progress, cf_done, cf_fire, gpr_any, lsu_error;
    word_t pc, pc_next, load_data;

    wb_instr_if instr_bus ();

    assign instr_bus.rd    = s4_rd;
    assign instr_bus.opr_a = s4_opr_a;
    assign instr_bus.opr_b = s4_opr_b;
    assign instr_bus.uop   = s4_uop;
    assign instr_bus.fu    = s4_fu;
    assign instr_bus.trap  = s4_trap;
    assign instr_bus.size  = s4_size;
    assign instr_bus.valid = s4_valid;

    // Redirect once per change
    assign cf_fire   = cf_req && cf_ack && !cf_done;
    assign trap_pc   = pc;
    assign trs_pc    = pc;
    assign trs_instr = s4_instr;

    wb_sequencer u_seq (
        .g_clk, .g_resetn, .instr(instr_bus.ctrl), .cf_req, .cf_ack, .int_trap_req,
        .gpr_any, .s4_busy, .progress, .cf_done, .csr_en, .gpr_wen, .trap_int,
        .exec_mret, .trs_valid, .hold_lsu_req
    );

    wb_pc_counter #(.PC_RESET_VALUE(PC_RESET_VALUE)) u_pc (
        .g_clk, .g_resetn, .progress, .cf_fire, .cf_target, .size(s4_size),
        .pc, .pc_next
    );

    wb_trap_unit u_trap (
        .instr(instr_bus.sink), .pc, .trap_int, .int_trap_cause, .lsu_error,
        .csr_error, .csr_mepc, .csr_mtvec, .vector_intrs, .cf_req, .cf_target,
        .trap_cpu, .trap_cause, .trap_mtval
    );

    wb_load_unit u_load (
        .g_clk, .g_resetn, .instr(instr_bus.sink), .progress, .dmem_req, .dmem_gnt,
        .dmem_error, .dmem_rdata, .load_data, .lsu_error
    );

    wb_result_mux u_mux (
        .instr(instr_bus.sink), .trap_int, .pc_next, .load_data, .csr_rdata,
        .csr_error, .csr_en, .gpr_any, .gpr_rd, .gpr_wdata, .csr_wr, .csr_wr_set,
        .csr_wr_clr, .csr_addr, .csr_wdata
    );

endmodule

`default_nettype wire

// File: test/wb_props.sv
`timescale 1ns/1ps
`default_nettype none

// Handshake and one-shot rules, bound into wb_sequencer
module wb_props (
    input logic g_clk,
    input logic g_resetn,
    input logic cf_req,
    input logic cf_ack,
    input logic cf_done,
    input logic gpr_wen,
    input logic csr_en,
    input logic progress
);

    // Open change request must survive until acked
    a_cf_req_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf_req && !cf_ack && !cf_done |=> cf_req)
        else $error("cf_req dropped before cf_ack");

    // Same instruction still held, so no second write
    a_gpr_wen_once: assert property (@(posedge g_clk) disable iff (!g_resetn)
        gpr_wen && !progress |=> !gpr_wen)
        else $error("gpr_wen high twice for one instruction");

    a_csr_en_once: assert property (@(posedge g_clk) disable iff (!g_resetn)
        csr_en && !progress |=> !csr_en)
        else $error("csr_en longer than one cycle");

endmodule

`default_nettype wire

// File: test/tb_frv_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frv_writeback import wb_pkg::*; ();

    localparam word_t PC_RESET      = 32'h8000_0000;
    localparam int    CLK_PERIOD    = 100;
    localparam int    RESET_CYCLES  = 8;
    localparam int    TEST_CYCLES   = 37;  // 4 + 14 + 4 + 6 + 4 + 5 over the six tests
    localparam int    MARGIN_CYCLES = 40;
    localparam int    BUSY_LIMIT    = 16;  // Longest stall a test may leave

    localparam fu_t FU_ALU = 6'b1 << P_FU_ALU;
    localparam fu_t FU_MUL = 6'b1 << P_FU_MUL;
    localparam fu_t FU_LSU = 6'b1 << P_FU_LSU;
    localparam fu_t FU_CFU = 6'b1 << P_FU_CFU;
    localparam fu_t FU_CSR = 6'b1 << P_FU_CSR;
    localparam fu_t FU_CRY = 6'b1 << P_FU_CRY;

    // DUT inputs
    logic        g_clk, g_resetn;
    reg_addr_t   s4_rd;
    word_t       s4_opr_a, s4_opr_b;
    uop_t        s4_uop;
    fu_t         s4_fu;
    logic        s4_trap, s4_valid;
    logic [1:0]  s4_size;
    logic [31:0] s4_instr;
    logic        int_trap_req, vector_intrs, csr_error, cf_ack;
    cause_t      int_trap_cause;
    word_t       csr_mepc, csr_mtvec, csr_rdata;
    logic        dmem_req, dmem_gnt, dmem_error;
    word_t       dmem_rdata;

    // DUT outputs
    logic        s4_busy, gpr_wen, trap_cpu, trap_int, exec_mret, trs_valid;
    reg_addr_t   gpr_rd;
    word_t       gpr_wdata, trap_mtval, trap_pc, trs_pc, csr_wdata, cf_target;
    cause_t      trap_cause;
    logic [31:0] trs_instr;
    logic        csr_en, csr_wr, csr_wr_set, csr_wr_clr, cf_req, hold_lsu_req;
    logic [11:0] csr_addr;

    // Checker state
    int          mismatches, failures;
    int          wen_cnt, csr_cnt, mret_cnt;  // Pulses seen for the held instruction
    word_t       wdata_seen;
    word_t       exp_pc;
    logic [15:0] lfsr_state;

    frv_writeback #(.PC_RESET_VALUE(PC_RESET)) DUT (.*);

    bind wb_sequencer wb_props u_props (
        .g_clk(g_clk), .g_resetn(g_resetn), .cf_req(cf_req), .cf_ack(cf_ack),
        .cf_done(cf_done), .gpr_wen(gpr_wen), .csr_en(csr_en), .progress(progress)
    );

    initial g_clk = 1'b0;
    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    // Helpers ----------------------------------------
    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic word_t rand_bits(input int count);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < count; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // Next PC when the held instruction steps on
    function automatic word_t sequential_pc();
        return exp_pc + 32'(s4_size) * 32'd2;
    endfunction

    task automatic report_mismatch(input string name, input word_t got, input word_t want);
        mismatches++;
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic sample_cycle();
        if (gpr_wen) begin
            wen_cnt++;
            wdata_seen = gpr_wdata;  // Last written value
        end
        if (csr_en)
            csr_cnt++;
        if (exec_mret)
            mret_cnt++;
    endtask

    // Present one instruction, call right after a falling edge
    task automatic issue(input fu_t fu, input uop_t uop, input reg_addr_t rd,
                         input word_t a, input word_t b, input logic [1:0] sz);
        s4_fu    = fu;
        s4_uop   = uop;
        s4_rd    = rd;
        s4_opr_a = a;
        s4_opr_b = b;
        s4_size  = sz;
        s4_trap  = 1'b0;
        s4_valid = 1'b1;
        s4_instr = rand_bits(32);
        wen_cnt  = 0;
        csr_cnt  = 0;
        mret_cnt = 0;
        #1;
        if (trs_pc !== exp_pc)
            report_mismatch("trs_pc", trs_pc, exp_pc);
        if (trs_instr !== s4_instr)
            report_mismatch("trs_instr", trs_instr, s4_instr);
        sample_cycle();
    endtask

    task automatic next_cycle();
        @(negedge g_clk);
        #1;
        sample_cycle();
    endtask

    task automatic raise_ack();
        @(negedge g_clk);
        cf_ack = 1'b1;
        #1;
        sample_cycle();
    endtask

    // Wait for the stage to take the instruction, next_pc is where it leads
    task automatic retire(input word_t next_pc);
        int waited;
        waited = 0;
        while (s4_busy && waited < BUSY_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (s4_busy)
            report_failure("s4_busy never dropped for the held instruction");
        if (!trs_valid)
            report_failure("no trace packet when the instruction retired");
        exp_pc = next_pc;
    endtask

    // Tests ----------------------------------------
    task automatic test_alu();
        word_t      a;
        reg_addr_t  rd;
        fu_t        fu;
        logic [1:0] sz;
        for (int n = 0; n < 4; n++) begin
            a  = rand_bits(32);
            rd = reg_addr_t'(rand_bits(5));
            fu = (n == 1) ? FU_MUL : (n == 2) ? FU_CRY : FU_ALU;
            sz = (n == 3) ? 2'd1 : 2'd2;  // One compressed length
            @(negedge g_clk);
            issue(fu, '0, rd, a, rand_bits(32), sz);
            if (gpr_rd !== rd)
                report_mismatch("gpr_rd", 32'(gpr_rd), 32'(rd));
            retire(sequential_pc());
            if (wen_cnt != 1)
                report_failure("gpr_wen not high for exactly one cycle on a result");
            if (wdata_seen !== a)
                report_mismatch("gpr_wdata", wdata_seen, a);
        end
    endtask

    task automatic test_load();
        word_t      data, addr, want;
        logic [1:0] code;
        logic [3:0] strb;
        logic       sbit;
        int         span;
        for (int sz = 0; sz < 3; sz++) begin
            for (int sgn = 0; sgn < 2; sgn++) begin
                span = 1 << sz;  // Bytes per access
                sbit = (sgn != 0);
                code = (sz == 0) ? LSU_BYTE : (sz == 1) ? LSU_HALF : LSU_WORD;
                for (int off = 0; off < 4; off += span) begin
                    data = rand_bits(32);
                    data[8 * (off + span) - 1] = 1'b1;  // Lane top bit set, extension shows
                    addr = (rand_bits(32) & ~32'h3) | 32'(off);
                    strb = 4'(((1 << span) - 1) << off);
                    want = data >> (8 * off);  // Addressed lane down to bit 0
                    if (span == 1)
                        want = (sbit && want[7]) ? (want | 32'hffff_ff00) : (want & 32'hff);
                    else if (span == 2)
                        want = (sbit && want[15]) ? (want | 32'hffff_0000) : (want & 32'hffff);
                    @(negedge g_clk);
                    dmem_rdata = data;
                    issue(FU_LSU, uop_t'({2'b01, code, sbit}), reg_addr_t'(rand_bits(5)),
                          (rand_bits(32) & 32'hffff_fff0) | 32'(strb), addr, 2'd2);
                    retire(sequential_pc());
                    if (wen_cnt != 1)
                        report_failure("load did not write its register once");
                    if (wdata_seen !== want)
                        report_mismatch("gpr_wdata", wdata_seen, want);
                end
            end
        end
    endtask

    task automatic test_csr();
        word_t a, b, rdata, mtvec;
        int    kind;
        a     = rand_bits(32);
        b     = rand_bits(32);
        rdata = rand_bits(32);
        mtvec = rand_bits(32) & ~32'h3;
        // Write, set and clear, each with a read
        for (int k = 0; k < 3; k++) begin
            kind = (k == 0) ? CSR_WRITE : (k == 1) ? CSR_SET : CSR_CLEAR;
            @(negedge g_clk);
            csr_rdata = rdata;
            csr_error = 1'b0;
            issue(FU_CSR, uop_t'((1 << CSR_READ) | (1 << kind)), 5'd7, a, b, 2'd2);
            if (csr_addr !== b[11:0])
                report_mismatch("csr_addr", 32'(csr_addr), 32'(b[11:0]));
            if (csr_wdata !== a)
                report_mismatch("csr_wdata", csr_wdata, a);
            if (csr_wr !== (kind == CSR_WRITE))
                report_failure("csr_wr does not match the access kind");
            if (csr_wr_set !== (kind == CSR_SET))
                report_failure("csr_wr_set does not match the access kind");
            if (csr_wr_clr !== (kind == CSR_CLEAR))
                report_failure("csr_wr_clr does not match the access kind");
            retire(sequential_pc());
            if (csr_cnt != 1)
                report_failure("csr_en did not pulse exactly once");
            if (wen_cnt != 1)
                report_failure("CSR read did not write its register once");
            if (wdata_seen !== rdata)
                report_mismatch("gpr_wdata", wdata_seen, rdata);
        end
        // Illegal access traps to mtvec
        @(negedge g_clk);
        csr_error = 1'b1;
        csr_mtvec = mtvec;
        issue(FU_CSR, uop_t'(1 << CSR_READ), 5'd9, a, b, 2'd2);
        if (trap_cause !== TRAP_IOPCODE)
            report_mismatch("trap_cause", 32'(trap_cause), 32'(TRAP_IOPCODE));
        if (cf_target !== mtvec)
            report_mismatch("cf_target", cf_target, mtvec);
        if (trap_pc !== exp_pc)
            report_mismatch("trap_pc", trap_pc, exp_pc);
        if (!trap_cpu)
            report_failure("trap_cpu low on an illegal CSR access");
        retire(mtvec);
        if (wen_cnt != 0)
            report_failure("register written by a failing CSR access");
    endtask

    task automatic test_jal();
        word_t     target, link;
        reg_addr_t rd;
        target = rand_bits(32) & ~32'h3;
        rd     = reg_addr_t'(rand_bits(5));
        @(negedge g_clk);
        cf_ack    = 1'b0;  // Back-pressure
        csr_error = 1'b0;
        issue(FU_CFU, CFU_JALI, rd, target, rand_bits(32), 2'd2);
        link = sequential_pc();
        repeat (4) begin
            if (!s4_busy)
                report_failure("s4_busy low while cf_ack is held low");
            if (!cf_req)
                report_failure("cf_req dropped while cf_ack is held low");
            if (cf_target !== target)
                report_mismatch("cf_target", cf_target, target);
            if (!hold_lsu_req)
                report_failure("hold_lsu_req low during a control flow change");
            if (trs_valid)
                report_failure("trace packet emitted while stalled");
            next_cycle();
        end
        raise_ack();
        retire(target);
        if (wen_cnt != 1)
            report_failure("link register not written exactly once under back-pressure");
        if (wdata_seen !== link)
            report_mismatch("gpr_wdata", wdata_seen, link);
    endtask

    task automatic test_irq();
        word_t  mtvec, target;
        cause_t cause;
        mtvec  = rand_bits(32) & 32'hffff_ff00;
        cause  = cause_t'(rand_bits(4)) | 6'h10;  // Local interrupt range, never zero
        target = mtvec + 32'(cause) * 32'd4;  // Vectored entry
        @(negedge g_clk);
        cf_ack         = 1'b0;
        vector_intrs   = 1'b1;
        csr_mtvec      = mtvec;
        int_trap_req   = 1'b1;
        int_trap_cause = cause;
        issue(FU_ALU, '0, 5'd3, rand_bits(32), rand_bits(32), 2'd2);
        for (int n = 0; n < 2; n++) begin
            if (!trap_int)
                report_failure("trap_int low with an interrupt pending");
            if (trap_cause !== cause)
                report_mismatch("trap_cause", 32'(trap_cause), 32'(cause));
            if (cf_target !== target)
                report_mismatch("cf_target", cf_target, target);
            @(negedge g_clk);
            int_trap_req = 1'b0;  // Pending flag carries it on
            #1;
            sample_cycle();
        end
        raise_ack();
        retire(target);
        if (wen_cnt != 0)
            report_failure("register written by an interrupted instruction");
    endtask

    task automatic test_bus_error_mret();
        word_t addr, mepc;
        addr = rand_bits(32) & ~32'h3;
        mepc = rand_bits(32) & ~32'h3;
        @(negedge g_clk);
        s4_valid = 1'b0;  // Request cycle ahead of the load
        dmem_req = 1'b1;
        dmem_gnt = 1'b1;
        @(negedge g_clk);
        dmem_req   = 1'b0;
        dmem_gnt   = 1'b0;
        dmem_error = 1'b1;
        dmem_rdata = rand_bits(32);
        issue(FU_LSU, uop_t'({2'b01, LSU_WORD, 1'b0}), 5'd4, 32'hf, addr, 2'd2);
        if (trap_cause !== TRAP_LDACCESS)
            report_mismatch("trap_cause", 32'(trap_cause), 32'(TRAP_LDACCESS));
        if (trap_mtval !== addr)
            report_mismatch("trap_mtval", trap_mtval, addr);
        retire(csr_mtvec);
        // MRET back to mepc
        @(negedge g_clk);
        dmem_error = 1'b0;
        cf_ack     = 1'b0;
        csr_mepc   = mepc;
        issue(FU_CFU, CFU_MRET, 5'd0, 32'd0, 32'd0, 2'd2);
        if (cf_target !== mepc)
            report_mismatch("cf_target", cf_target, mepc);
        if (exec_mret)
            report_failure("exec_mret high before the change was acknowledged");
        raise_ack();
        retire(mepc);
        if (mret_cnt != 1)
            report_failure("exec_mret did not pulse exactly once");
        @(negedge g_clk);
        s4_valid = 1'b0;
        #1;
        if (trs_pc !== exp_pc)
            report_mismatch("trs_pc", trs_pc, exp_pc);
    endtask

    // Main sequence ----------------------------------------
    initial begin
        mismatches     = 0;
        failures       = 0;
        lfsr_state     = 16'd26;
        exp_pc         = PC_RESET;
        g_resetn       = 1'b0;
        s4_rd          = '0;
        s4_opr_a       = '0;
        s4_opr_b       = '0;
        s4_uop         = '0;
        s4_fu          = '0;
        s4_trap        = 1'b0;
        s4_size        = '0;
        s4_instr       = '0;
        s4_valid       = 1'b0;
        int_trap_req   = 1'b0;
        int_trap_cause = '0;
        csr_mepc       = '0;
        csr_mtvec      = '0;
        vector_intrs   = 1'b0;
        csr_rdata      = '0;
        csr_error      = 1'b0;
        cf_ack         = 1'b1;  // Changes complete at once unless a test stalls
        dmem_req       = 1'b0;
        dmem_gnt       = 1'b0;
        dmem_error     = 1'b0;
        dmem_rdata     = '0;
        repeat (RESET_CYCLES) @(negedge g_clk);
        g_resetn = 1'b1;
        #1;
        if (gpr_wen || csr_en || cf_req || trs_valid || exec_mret || s4_busy)
            report_failure("control outputs active with no valid instruction after reset");
        test_alu();
        test_load();
        test_csr();
        test_jal();
        test_irq();
        test_bus_error_mret();
        $display("%0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // Watchdog
    initial begin
        #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog timeout, run did not finish in %0d cycles",
                 RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: frv_writeback.f
common/wb_pkg.sv
common/wb_instr_if.sv
writeback_ctrl/wb_sequencer.sv
writeback_ctrl/wb_pc_counter.sv
writeback_ctrl/wb_trap_unit.sv
design/wb_load_unit.sv
design/wb_result_mux.sv
design/frv_writeback.sv
test/wb_props.sv
test/tb_frv_writeback.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the writeback testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f frv_writeback.f \
    --top-module tb_frv_writeback --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    exit 0
fi
exit 1
